/* all.f */
hdl/ramUnitPkg.sv
hdl/ramCmdQueue.sv
hdl/ramIf.sv
hdl/ramReadAssembler.sv
hdl/ramUnit.sv
testbench/tbClockGen.sv
testbench/sramModel.sv
testbench/ramUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# The run passes only if the simulation prints the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ramUnitTb -f all.f -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -qxF -- '** PASS **' \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* testbench/ramUnit_patterns.txt */
# Kinds: W busAdrs wdata | R busAdrs id expWord | P byteAdrs expByte, all hex
# Unwritten bytes hold the SRAM model fill adrs[7:0]^adrs[15:8]^adrs[18:16]
W 00001234 beef
R 00001234 1 beef
P 01234 ef
P 01235 be
P 01233 21
P 01236 24
W 00002000 1111
W 00002002 2222
W fff7fffe a55a
R 00002002 2 2222
R 0007fffe 3 a55a
R 00002000 4 1111
R 00002006 5 2726
P 7ffff a5
P 7fffd 05
W 00003000 c000
W 00003002 c001
W 00003004 c002
W 00003006 c003
W 00003008 c004
W 0000300a c005
W 0000300c c006
W 0000300e c007
W 00003010 c008
W 00003012 c009
R 00003000 6 c000
R 00003012 7 c009
P 0300a 05
P 0300b c0
P 02fff d0
P 03014 24

/* testbench/ramUnitTb.sv */
// Queue depth 4 here; a peek waits for all earlier reads, so the pattern file puts a read before it
`timescale 1ns/1ps

module ramUnitTb;

	localparam int unsigned	seedVal			= 32'hf892_5ab9;
	localparam int			cyclesPerLine	= 40;	// Timeout budget per pattern line
	localparam int			cycleSlack		= 200;	// Reset and final drain
	localparam int			tbFifoDepth		= 4;	// Small, so a short burst fills it

	logic					sysClk;
	logic					rst;
	logic					req;
	ramUnitPkg::busAdrs_t	adrs;
	ramUnitPkg::busWord_t	wd;
	logic					isRead;
	ramUnitPkg::reqId_t		idI;
	logic					rdy;
	logic					rspVd;
	ramUnitPkg::ramRsp_t	rsp;
	ramUnitPkg::ramAdrs_t	memAdrs;
	wire ramUnitPkg::ramByte_t	memDq;
	logic					memCeN;
	logic					memWeN;
	logic					memOeN;

	string					kinds[$];		// W, R or P per line
	logic [31:0]			fieldA[$];
	logic [31:0]			fieldB[$];
	logic [31:0]			fieldC[$];
	ramUnitPkg::busWord_t	expWords[$];	// Read words in issue order
	ramUnitPkg::reqId_t		expIds[$];
	int						rspIdx = 0;		// Responses seen so far
	int						valueErrs = 0;
	int						otherErrs = 0;
	int						rspErrs = 0;
	int						strayErrs = 0;
	int						cycles = 0;
	int						cycleLimit = cycleSlack;
	logic					rdyFell = 1'b0;	// Back-pressure seen

	tbClockGen clk0 (.sysClk(sysClk), .rst(rst));

	ramUnit #(.pFifoDepth(tbFifoDepth), .pAccessCycles(1)) dut0 (
		.sysClk(sysClk), .rst(rst), .req(req), .adrs(adrs), .wd(wd), .isRead(isRead),
		.idI(idI), .rdy(rdy), .rspVd(rspVd), .rsp(rsp), .memAdrs(memAdrs),
		.memDq(memDq), .memCeN(memCeN), .memWeN(memWeN), .memOeN(memOeN)
	);

	sramModel sram0 (
		.memAdrs(memAdrs), .memDq(memDq), .memCeN(memCeN), .memWeN(memWeN), .memOeN(memOeN)
	);

	// ----------------------------------------
	// Pattern file and bus driver
	// ----------------------------------------
	task automatic loadPatterns();
		int fd;
		int n;
		string kind;
		string rest;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("testbench/ramUnit_patterns.txt", "r");
		if (fd == 0)
		begin
			otherErrs++;
			$display("Could not open the pattern file testbench/ramUnit_patterns.txt");
		end
		else
		begin
			while ($fscanf(fd, "%s", kind) == 1)
			begin
				c = '0;
				if (kind.getc(0) == "#")
					n = $fgets(rest, fd);	// Skip comment line
				else if (kind == "W" || kind == "R" || kind == "P")
				begin
					if (kind == "R")
						n = $fscanf(fd, "%h %h %h", a, b, c);
					else
						n = $fscanf(fd, "%h %h", a, b);
					if (n != ((kind == "R") ? 3 : 2))
					begin
						otherErrs++;
						$display("Pattern line of kind %s has missing or bad fields", kind);
					end
					kinds.push_back(kind);
					fieldA.push_back(a);
					fieldB.push_back(b);
					fieldC.push_back(c);
				end
				else
				begin
					otherErrs++;
					$display("Pattern file holds an unknown line kind %s", kind);
				end
			end
			$fclose(fd);
		end
	endtask

	// One request, taken on the second edge; rdy looked at while stable
	task automatic issueReq(
		input logic					rd,
		input ramUnitPkg::busAdrs_t	a,
		input ramUnitPkg::busWord_t	d,
		input ramUnitPkg::reqId_t	id,
		input ramUnitPkg::busWord_t	exp
	);
		int gap;
		gap = $urandom % 2;		// Random idle gap
		repeat (gap) @(posedge sysClk);
		@(negedge sysClk);
		while (!rdy)
			@(negedge sysClk);	// Queue full, hold off
		@(posedge sysClk);
		req		<= 1'b1;
		adrs	<= a;
		wd		<= d;
		isRead	<= rd;
		idI		<= id;
		@(posedge sysClk);		// Queue takes it here
		req		<= 1'b0;
		if (rd)
		begin
			expWords.push_back(exp);
			expIds.push_back(id);
		end
	endtask

	task automatic waitReadsDone();
		while (rspIdx < expWords.size())
			@(negedge sysClk);
	endtask

	task automatic checkIdlePins();
		assert (memCeN && memWeN && memOeN && !rspVd && rdy)
		else
		begin
			valueErrs++;
			$display("CHECK FAILED %0t ns: pins or bus not idle around reset", $time);
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		int i;
		req		<= 1'b0;
		adrs	<= '0;
		wd		<= '0;
		isRead	<= 1'b0;
		idI		<= '0;
		void'($urandom(seedVal));
		loadPatterns();
		cycleLimit = cyclesPerLine * kinds.size() + cycleSlack;
		do
		begin
			@(negedge sysClk);
			checkIdlePins();	// Last pass is just after release
		end
		while (rst);
		for (i = 0; i < kinds.size(); i++)
		begin
			if (kinds[i] == "W")
				issueReq(1'b0, fieldA[i], fieldB[i][15:0], '0, '0);
			else if (kinds[i] == "R")
				issueReq(1'b1, fieldA[i], '0, fieldB[i][2:0], fieldC[i][15:0]);
			else
			begin
				waitReadsDone();	// Earlier writes have landed
				assert (sram0.peekByte(fieldA[i][18:0]) == fieldB[i][7:0])
				else
				begin
					valueErrs++;
					$display("CHECK FAILED %0t ns: byte %h holds %h, expected %h", $time,
						fieldA[i][18:0], sram0.peekByte(fieldA[i][18:0]), fieldB[i][7:0]);
				end
			end
		end
		waitReadsDone();
		assert (rdyFell)
		else
		begin
			valueErrs++;
			$display("CHECK FAILED %0t ns: rdy never fell during the write burst", $time);
		end
		$display("Done: %0d value errors, %0d other errors",
			valueErrs + rspErrs, otherErrs + strayErrs);
		if (valueErrs + rspErrs + otherErrs + strayErrs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// ----------------------------------------
	// Response checker, mid-cycle
	// ----------------------------------------
	always @(negedge sysClk)
	begin
		if (!rst)
		begin
			if (!rdy)
				rdyFell <= 1'b1;
			if (rspVd)
			begin
				assert (rspIdx < expWords.size())
				else
				begin
					strayErrs++;
					$display("Read response at %0t ns came with no read outstanding", $time);
				end
				if (rspIdx < expWords.size())
				begin
					assert (rsp.rd == expWords[rspIdx] && rsp.id == expIds[rspIdx])
					else
					begin
						rspErrs++;
						$display("CHECK FAILED %0t ns: read gave id %0d word %h, expected %0d %h",
							$time, rsp.id, rsp.rd, expIds[rspIdx], expWords[rspIdx]);
					end
					rspIdx <= rspIdx + 1;
				end
			end
		end
	end

	// Run limit
	always @(posedge sysClk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("Timeout: run not finished after %0d cycles, %0d value errors so far",
				cycles, valueErrs + rspErrs);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

/* testbench/sramModel.sv */
// Untimed async byte SRAM of 512K bytes; power-up fill is adrs[7:0]^adrs[15:8]^adrs[18:16]
`timescale 1ns/1ps

module sramModel (
	input	ramUnitPkg::ramAdrs_t	memAdrs,
	inout	ramUnitPkg::ramByte_t	memDq,
	input	logic					memCeN,
	input	logic					memWeN,
	input	logic					memOeN
);

	ramUnitPkg::ramByte_t	mem [1 << 19];	// Whole byte space

	// Drive out only on a plain read
	assign memDq = (!memCeN && !memOeN && memWeN) ? mem[memAdrs] : 'z;

	initial
	begin
		int i;
		for (i = 0; i < (1 << 19); i++)
			mem[i] = i[7:0] ^ i[15:8] ^ {5'b0, i[18:16]};	// Every address bit counts
	end

	// Writes through for as long as WE is low
	always @(*)
	begin
		if (!memCeN && !memWeN)
			mem[memAdrs] = memDq;
	end

	// Backdoor read for checks
	function automatic ramUnitPkg::ramByte_t peekByte(input ramUnitPkg::ramAdrs_t a);
		return mem[a];
	endfunction

endmodule

/* testbench/tbClockGen.sv */
// Free-running 100 ns clock from time zero; rst high until the 16th rising edge
`timescale 1ns/1ps

module tbClockGen (
	output	logic	sysClk,
	output	logic	rst
);

	initial
	begin
		sysClk = 1'b0;
		forever #50 sysClk = ~sysClk;	// 100 ns period
	end

	initial
	begin
		rst <= 1'b1;
		repeat (16) @(posedge sysClk);
		rst <= 1'b0;	// Released on 16th edge
	end

endmodule

/* hdl/ramUnit.sv */
// Single clock domain; read responses are one-cycle pulses the master must accept
`timescale 1ns/1ps

module ramUnit #(
	parameter int pFifoDepth	= 16,	// Request queue entries
	parameter int pAccessCycles	= 1		// Strobe cycles per byte
)(
	input	logic					sysClk,
	input	logic					rst,
	// Bus request
	input	logic					req,
	input	ramUnitPkg::busAdrs_t	adrs,
	input	ramUnitPkg::busWord_t	wd,
	input	logic					isRead,
	input	ramUnitPkg::reqId_t		idI,
	output	logic					rdy,
	// Bus response
	output	logic					rspVd,
	output	ramUnitPkg::ramRsp_t	rsp,
	// SRAM pins
	output	ramUnitPkg::ramAdrs_t	memAdrs,
	inout	ramUnitPkg::ramByte_t	memDq,
	output	logic					memCeN,
	output	logic					memWeN,
	output	logic					memOeN
);

	ramUnitPkg::ramReq_t	head;
	logic					notEmpty;
	logic					pop;
	logic					byteVd;
	logic					byteHi;
	ramUnitPkg::ramByte_t	byteData;
	ramUnitPkg::reqId_t		byteId;

	// ----------------------------------------
	// Decode, execute, result
	// ----------------------------------------
	ramCmdQueue #(.pFifoDepth(pFifoDepth)) cmdQueue0 (
		.sysClk(sysClk), .rst(rst), .req(req), .adrs(adrs), .wd(wd),
		.isRead(isRead), .idI(idI), .rdy(rdy), .head(head),
		.notEmpty(notEmpty), .pop(pop)
	);

	ramIf #(.pAccessCycles(pAccessCycles)) ramIf0 (
		.sysClk(sysClk), .rst(rst), .head(head), .notEmpty(notEmpty), .pop(pop),
		.memAdrs(memAdrs), .memDq(memDq), .memCeN(memCeN), .memWeN(memWeN),
		.memOeN(memOeN), .byteVd(byteVd), .byteHi(byteHi), .byteData(byteData),
		.byteId(byteId)
	);

	ramReadAssembler readAsm0 (
		.sysClk(sysClk), .rst(rst), .byteVd(byteVd), .byteHi(byteHi),
		.byteData(byteData), .byteId(byteId), .rspVd(rspVd), .rsp(rsp)
	);

endmodule

/* hdl/ramReadAssembler.sv */
// Expects low byte before high byte of the same request; no back-pressure on rspVd
`timescale 1ns/1ps

module ramReadAssembler (
	input	logic					sysClk,
	input	logic					rst,
	// From sequencer
	input	logic					byteVd,
	input	logic					byteHi,
	input	ramUnitPkg::ramByte_t	byteData,
	input	ramUnitPkg::reqId_t		byteId,
	// Bus response
	output	logic					rspVd,
	output	ramUnitPkg::ramRsp_t	rsp
);

	ramUnitPkg::ramByte_t	lowByte;	// Held until high byte
	ramUnitPkg::reqId_t		lowId;		// Tag of held byte
	logic					lowVd;		// Low byte waiting

	// ----------------------------------------
	// Word join and response pulse
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			rspVd	<= 1'b0;
			lowVd	<= 1'b0;
		end
		else
		begin
			rspVd <= byteVd & byteHi;
			if (byteVd)
				lowVd <= ~byteHi;	// Set by low, cleared by high
		end
	end

	// Payload, no reset
	always_ff @(posedge sysClk)
	begin
		if (byteVd && !byteHi)
		begin
			lowByte	<= byteData;
			lowId	<= byteId;
		end
		if (byteVd && byteHi)
		begin
			rsp.rd	<= {byteData, lowByte};	// High byte on top
			rsp.id	<= byteId;
		end
	end

	// Both halves come from one request
	assert property (@(posedge sysClk) disable iff (rst)
		(byteVd && byteHi) |-> (lowVd && lowId == byteId))
		else $error("ramReadAssembler: high byte without matching low at %0t", $time);

endmodule

/* hdl/ramIf.sv */
// Async byte SRAM assumed; address and data change on the edge that ends a strobe (zero hold)
`timescale 1ns/1ps

module ramIf #(
	parameter int pAccessCycles = 1
)(
	input	logic					sysClk,
	input	logic					rst,
	// Queue side
	input	ramUnitPkg::ramReq_t	head,
	input	logic					notEmpty,
	output	logic					pop,
	// SRAM pins
	output	ramUnitPkg::ramAdrs_t	memAdrs,
	inout	ramUnitPkg::ramByte_t	memDq,
	output	logic					memCeN,
	output	logic					memWeN,
	output	logic					memOeN,
	// Read bytes to assembler
	output	logic					byteVd,
	output	logic					byteHi,
	output	ramUnitPkg::ramByte_t	byteData,
	output	ramUnitPkg::reqId_t		byteId
);

	localparam int cntW = (pAccessCycles > 1) ? $clog2(pAccessCycles) : 1;

	ramUnitPkg::ifState_t	state;
	ramUnitPkg::ramReq_t	reqLat;		// Request in flight
	ramUnitPkg::ramByte_t	dqOut;		// Write byte on pins
	logic					dqEn;		// Pin driver enable
	logic [cntW-1:0]		strbCnt;	// Strobe cycle count
	logic					lastStrb;

	assign pop		= (state == ramUnitPkg::IDLE) & notEmpty;
	assign lastStrb	= (strbCnt == cntW'(pAccessCycles - 1));
	assign memDq	= dqEn ? dqOut : 'z;	// Released outside write strobe

	// ----------------------------------------
	// Pin sequencer
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		byteVd <= 1'b0;		// Single-cycle pulse
		if (rst)
		begin
			state	<= ramUnitPkg::IDLE;
			memCeN	<= 1'b1;
			memWeN	<= 1'b1;
			memOeN	<= 1'b1;
			dqEn	<= 1'b0;
			strbCnt	<= '0;
		end
		else
		begin
			case (state)
				ramUnitPkg::IDLE:
				begin
					if (pop)
					begin
						reqLat	<= head;
						memAdrs	<= {head.wordAdrs, 1'b0};	// Low byte, even address
						dqOut	<= head.wd[7:0];
						memCeN	<= 1'b0;
						state	<= ramUnitPkg::SETUP_LO;
					end
				end
				ramUnitPkg::SETUP_LO, ramUnitPkg::SETUP_HI:
				begin
					strbCnt <= '0;
					if (reqLat.isRead)
						memOeN <= 1'b0;
					else
					begin
						memWeN	<= 1'b0;
						dqEn	<= 1'b1;
					end
					state <= (state == ramUnitPkg::SETUP_LO) ?
						ramUnitPkg::STROBE_LO : ramUnitPkg::STROBE_HI;
				end
				ramUnitPkg::STROBE_LO, ramUnitPkg::STROBE_HI:
				begin
					if (lastStrb)
					begin
						memWeN		<= 1'b1;
						memOeN		<= 1'b1;
						dqEn		<= 1'b0;
						byteVd		<= reqLat.isRead;	// Only reads go on
						byteHi		<= (state == ramUnitPkg::STROBE_HI);
						byteData	<= memDq;			// Sample under OE
						byteId		<= reqLat.id;
						if (state == ramUnitPkg::STROBE_LO)
						begin
							memAdrs	<= {reqLat.wordAdrs, 1'b1};	// High byte, odd address
							dqOut	<= reqLat.wd[15:8];
							state	<= ramUnitPkg::SETUP_HI;
						end
						else
						begin
							memCeN	<= 1'b1;
							state	<= ramUnitPkg::DONE;
						end
					end
					else
						strbCnt <= strbCnt + 1'b1;
				end
				default:	// DONE, one turnaround cycle
					state <= ramUnitPkg::IDLE;
			endcase
		end
	end

	// Bus contention on the SRAM pins
	assert property (@(posedge sysClk) disable iff (rst) !(!memWeN && !memOeN))
		else $error("ramIf: WE and OE low together at %0t", $time);
	assert property (@(posedge sysClk) disable iff (rst) dqEn |-> (!memWeN && !memCeN))
		else $error("ramIf: data driven outside write strobe at %0t", $time);

endmodule

/* hdl/ramCmdQueue.sv */
// Master must hold req low while rdy is low; a request while full is dropped and flagged
`timescale 1ns/1ps

module ramCmdQueue #(
	parameter int pFifoDepth = 16
)(
	input	logic					sysClk,
	input	logic					rst,
	// Bus request side
	input	logic					req,
	input	ramUnitPkg::busAdrs_t	adrs,
	input	ramUnitPkg::busWord_t	wd,
	input	logic					isRead,
	input	ramUnitPkg::reqId_t		idI,
	output	logic					rdy,
	// Sequencer side
	output	ramUnitPkg::ramReq_t	head,
	output	logic					notEmpty,
	input	logic					pop
);

	localparam int ptrW = (pFifoDepth > 1) ? $clog2(pFifoDepth) : 1;
	localparam int cntW = $clog2(pFifoDepth + 1);

	ramUnitPkg::ramReq_t	fifoMem [pFifoDepth];	// Request storage
	logic [ptrW-1:0]		wrPtr;
	logic [ptrW-1:0]		rdPtr;
	logic [cntW-1:0]		count;					// Entries held
	logic					push;

	// ----------------------------------------
	// Status
	// ----------------------------------------
	assign rdy		= (count != cntW'(pFifoDepth));	// Low while full
	assign notEmpty	= (count != '0);
	assign push		= req & rdy;
	assign head		= fifoMem[rdPtr];				// Show-ahead head

	// Payload store, no reset
	always_ff @(posedge sysClk)
	begin
		if (push)
		begin
			fifoMem[wrPtr].isRead	<= isRead;
			fifoMem[wrPtr].wordAdrs	<= adrs[18:1];	// Drop byte-in-word bit
			fifoMem[wrPtr].wd		<= wd;
			fifoMem[wrPtr].id		<= idI;
		end
	end

	// ----------------------------------------
	// Pointers and count
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			count	<= '0;
		end
		else
		begin
			if (push)	// Wrap for any depth, not just powers of two
				wrPtr <= (wrPtr == ptrW'(pFifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrW'(pFifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (!push && pop)
				count <= count - 1'b1;
		end
	end

	// Master honours rdy
	assert property (@(posedge sysClk) disable iff (rst) req |-> rdy)
		else $error("ramCmdQueue: request while full at %0t", $time);
	// Sequencer only pops real entries
	assert property (@(posedge sysClk) disable iff (rst) pop |-> notEmpty)
		else $error("ramCmdQueue: pop while empty at %0t", $time);

endmodule

/* hdl/ramUnitPkg.sv */
// Fixed 16-bit bus and 8-bit SRAM widths; only bus address bits 18:1 reach the SRAM word address
package ramUnitPkg;

	// ----------------------------------------
	// Bus side widths
	// ----------------------------------------
	typedef logic [15:0]	busWord_t;		// Bus data word
	typedef logic [31:0]	busAdrs_t;		// Bus byte address
	typedef logic [2:0]		reqId_t;		// Request tag, echoed on read response

	// ----------------------------------------
	// SRAM side widths
	// ----------------------------------------
	typedef logic [18:0]	ramAdrs_t;		// SRAM byte address, word address plus byte bit
	typedef logic [7:0]		ramByte_t;		// SRAM data byte

	// Queued request, one 16-bit word
	typedef struct packed {
		logic			isRead;				// High read, low write
		logic [17:0]	wordAdrs;			// SRAM word address
		busWord_t		wd;					// Write word, unused on read
		reqId_t			id;
	} ramReq_t;

	// Read response, valid with rspVd
	typedef struct packed {
		busWord_t		rd;					// Assembled read word
		reqId_t			id;
	} ramRsp_t;

	// Pin sequencer, low byte first
	typedef enum logic [2:0] {
		IDLE, SETUP_LO, STROBE_LO, SETUP_HI, STROBE_HI, DONE
	} ifState_t;

endpackage
